// File: Makefile
# Verilator build and run for the DSP core front end
VERILATOR ?= verilator
TOP       ?= tb_dsp_core
RTL_TOP   ?= dsp_core
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= SIMULATION FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/dsp_core.sv
// Core top; program memory is external and must return instr for the pc of the previous cycle
`timescale 1ns/1ps
`include "dsp_consts.svh"

module dsp_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  dsp_pkg::instr_u      instr,
    output logic [`DSP_PC_W-1:0] pc,
    output dsp_pkg::wr_evt_t     wr_evt
);

    dsp_pkg::ctrl_t         ctrl;
    logic [`DSP_RAM_AW-1:0] ram_addr;
    logic [`DSP_WORD_W-1:0] st_data;
    logic [`DSP_WORD_W-1:0] ld_data;

    dsp_fetch u_fetch (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .ctrl (ctrl),
        .pc   (pc)
    );

    dsp_decode u_decode (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .instr (instr),
        .ctrl  (ctrl)
    );

    dsp_yaau u_yaau (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ctrl     (ctrl),
        .ld_data  (ld_data),
        .ram_addr (ram_addr),
        .st_data  (st_data)
    );

    dsp_dmem u_dmem (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ctrl     (ctrl),
        .ram_addr (ram_addr),
        .st_data  (st_data),
        .ld_data  (ld_data),
        .wr_evt   (wr_evt)
    );

endmodule

// File: hdl/dsp_decode.sv
// Registered decoder for the Y-unit subset; unknown opcodes and non-zero groups do nothing
`timescale 1ns/1ps
`include "dsp_consts.svh"

module dsp_decode (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    input  dsp_pkg::instr_u instr,
    output dsp_pkg::ctrl_t  ctrl
);

    // What the next sampled word is for
    localparam logic [1:0] SW_NONE = 2'd0;
    localparam logic [1:0] SW_LONG = 2'd1;   // Long immediate data
    localparam logic [1:0] SW_SLOT = 2'd2;   // Discarded word

    logic [1:0] sw_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl     <= '0;
            sw_state <= SW_NONE;
        end else if (cen) begin
            ctrl.jmp      <= 1'b0;
            ctrl.reg_load <= 1'b0;
            ctrl.ram_we   <= 1'b0;
            ctrl.ram_rd   <= 1'b0;
            sw_state      <= SW_NONE;

            case (sw_state)
                SW_LONG: begin
                    // reg_sel was set by the first word
                    ctrl.imm      <= instr;
                    ctrl.reg_load <= 1'b1;
                end
                SW_SLOT: begin
                    // Word after a jump or a dropped long immediate
                end
                default: begin
                    casez (instr.jmp_fmt.t)
                        `DSP_T_GOTO: begin
                            ctrl.jmp        <= 1'b1;
                            ctrl.jmp_target <= {instr.jmp_fmt.t[0], instr.jmp_fmt.ja};
                            sw_state        <= SW_SLOT;
                        end
                        `DSP_T_SHORT: begin
                            ctrl.reg_load <= 1'b1;
                            ctrl.reg_sel  <= instr.imm_fmt.rf ^ 3'b100;
                            ctrl.imm      <= {7'd0, instr.imm_fmt.imm};   // Zero-extended
                        end
                        `DSP_T_LONG: begin
                            ctrl.reg_sel <= instr.mem_fmt.rf;
                            if (instr.mem_fmt.grp == 3'd0) begin
                                sw_state <= SW_LONG;
                            end else begin
                                sw_state <= SW_SLOT;   // Other units are not present
                            end
                        end
                        `DSP_T_STORE, `DSP_T_LOAD: begin
                            if (instr.mem_fmt.grp == 3'd0) begin
                                ctrl.ram_we <= instr.mem_fmt.t == `DSP_T_STORE;
                                ctrl.ram_rd <= instr.mem_fmt.t == `DSP_T_LOAD;
                            end
                            ctrl.reg_sel <= instr.mem_fmt.rf;
                            ctrl.ptr_sel <= instr.mem_fmt.ysel;
                            ctrl.mod_sel <= instr.mem_fmt.mod;
                        end
                        default: begin
                            // No operation
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

// File: hdl/dsp_dmem.sv
// 256x16 data RAM with asynchronous read and no reset; wr_evt mirrors each store for one cycle
`timescale 1ns/1ps
`include "dsp_consts.svh"

module dsp_dmem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  dsp_pkg::ctrl_t         ctrl,
    input  logic [`DSP_RAM_AW-1:0] ram_addr,
    input  logic [`DSP_WORD_W-1:0] st_data,
    output logic [`DSP_WORD_W-1:0] ld_data,
    output dsp_pkg::wr_evt_t       wr_evt
);

    logic [`DSP_WORD_W-1:0] mem [1 << `DSP_RAM_AW];
    logic                   evt_valid;
    logic [`DSP_RAM_AW-1:0] evt_addr;
    logic [`DSP_WORD_W-1:0] evt_data;

    assign ld_data = mem[ram_addr];   // Pointer value before post-modify

    always_ff @(posedge clk) begin
        if (cen && ctrl.ram_we) begin
            mem[ram_addr] <= st_data;
        end
    end

    // Event payload, only meaningful with evt_valid
    always_ff @(posedge clk) begin
        if (cen && ctrl.ram_we) begin
            evt_addr <= ram_addr;
            evt_data <= st_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            evt_valid <= 1'b0;
        end else if (cen) begin
            evt_valid <= ctrl.ram_we;   // Drops on the next enabled edge
        end
    end

    assign wr_evt = '{valid: evt_valid, addr: evt_addr, data: evt_data};

endmodule

// File: hdl/dsp_fetch.sv
// Program counter only; program memory sits outside and returns the word one cycle later
`timescale 1ns/1ps
`include "dsp_consts.svh"

module dsp_fetch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  dsp_pkg::ctrl_t       ctrl,
    output logic [`DSP_PC_W-1:0] pc
);

    logic [`DSP_PC_W-1:0] pc_next;

    // Jump strobe comes one cycle after the goto word was sampled
    always_comb begin
        if (ctrl.jmp) begin
            pc_next = ctrl.jmp_target;
        end else begin
            pc_next = pc + 1'b1;   // Wraps at 12 bits
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (cen) begin
            pc <= pc_next;
        end
    end

endmodule

// File: hdl/dsp_pkg.sv
// Instruction views and pipeline bundles; field widths assume the sizes in dsp_consts.svh
`include "dsp_consts.svh"

package dsp_pkg;

    // goto JA: bit 11 is the low T bit and also the top target bit
    typedef struct packed {
        logic [4:0]  t;
        logic [10:0] ja;
    } jmp_fmt_t;

    // Short immediate, register code in bits 11 to 9
    typedef struct packed {
        logic [3:0] pfx;
        logic [2:0] rf;    // Top bit inverted gives the register index
        logic [8:0] imm;
    } imm_fmt_t;

    // Long immediate, RAM store and RAM load
    typedef struct packed {
        logic [4:0] t;
        logic       spare;
        logic [2:0] grp;   // Destination group, 0 is the Y address unit
        logic [2:0] rf;
        logic [1:0] ysel;  // Pointer r0 to r3
        logic [1:0] mod;   // none, ++, --, +=j
    } mem_fmt_t;

    typedef union packed {
        jmp_fmt_t jmp_fmt;
        imm_fmt_t imm_fmt;
        mem_fmt_t mem_fmt;
    } instr_u;

    // Decode to execute, strobes last one enabled cycle
    typedef struct packed {
        logic                   jmp;
        logic                   reg_load;
        logic                   ram_we;
        logic                   ram_rd;
        logic [`DSP_PC_W-1:0]   jmp_target;
        logic [2:0]             reg_sel;
        logic [1:0]             ptr_sel;
        logic [1:0]             mod_sel;
        logic [`DSP_WORD_W-1:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        logic [`DSP_RAM_AW-1:0] addr;
        logic [`DSP_WORD_W-1:0] data;
    } wr_evt_t;

endpackage

// File: hdl/dsp_yaau.sv
// Y address unit; only r0 to r3 address the RAM and only the low 8 pointer bits are used
`timescale 1ns/1ps
`include "dsp_consts.svh"

module dsp_yaau (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  dsp_pkg::ctrl_t         ctrl,
    input  logic [`DSP_WORD_W-1:0] ld_data,
    output logic [`DSP_RAM_AW-1:0] ram_addr,
    output logic [`DSP_WORD_W-1:0] st_data
);

    logic [`DSP_WORD_W-1:0] regs [`DSP_NREG];
    logic [2:0]             ptr_idx;
    logic [`DSP_WORD_W-1:0] ptr_val;
    logic [`DSP_WORD_W-1:0] step;

    assign ptr_idx  = {1'b0, ctrl.ptr_sel};
    assign ptr_val  = regs[ptr_idx];
    assign ram_addr = ptr_val[`DSP_RAM_AW-1:0];
    assign st_data  = regs[ctrl.reg_sel];

    always_comb begin
        case (ctrl.mod_sel)
            2'd1:    step = 16'd1;
            2'd2:    step = 16'hffff;          // -1
            2'd3:    step = regs[`DSP_REG_J];
            default: step = 16'd0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `DSP_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (cen) begin
            // Post-modify on the access edge
            if (ctrl.ram_we || ctrl.ram_rd) begin
                regs[ptr_idx] <= ptr_val + step;
            end
            if (ctrl.reg_load) begin
                regs[ctrl.reg_sel] <= ctrl.imm;
            end
            // Later assignment, so a load into the pointer beats its update
            if (ctrl.ram_rd) begin
                regs[ctrl.reg_sel] <= ld_data;
            end
        end
    end

endmodule

// File: include/dsp_consts.svh
// Core sizes and T-field opcodes; GOTO and SHORT patterns hold a ? bit and suit casez only
`ifndef DSP_CONSTS_SVH
`define DSP_CONSTS_SVH

`define DSP_WORD_W 16   // Data and instruction word
`define DSP_PC_W   12   // Program counter
`define DSP_RAM_AW 8    // Data RAM address, low bits of a pointer
`define DSP_NREG   8    // r0 r1 r2 r3 j k rb re

// Index of the j register, used by the +=j post-modify
`define DSP_REG_J  3'd4

// 5-bit T field of the program word
`define DSP_T_GOTO  5'b0000?
`define DSP_T_SHORT 5'b0001?
`define DSP_T_LONG  5'b01010
`define DSP_T_STORE 5'b01100
`define DSP_T_LOAD  5'b01111

`endif

// File: list.f
+incdir+include
hdl/dsp_pkg.sv
hdl/dsp_fetch.sv
hdl/dsp_decode.sv
hdl/dsp_yaau.sv
hdl/dsp_dmem.sv
hdl/dsp_core.sv
test/tb_dsp_core.sv

// File: test/tb_dsp_core.sv
// Rows stand in for program memory, so instr words are not tied to pc; at most 64 rows
`timescale 1ns/1ps
`include "dsp_consts.svh"

module tb_dsp_core;

    localparam int MAX_ROWS   = 64;
    localparam int RST_CYCLES = 8;
    localparam logic [15:0] NOP_WORD  = 16'hf000;   // T field 11110 has no opcode
    localparam logic [15:0] LONG_DATA = 16'h0a5c;   // Goto pattern, must not jump
    localparam dsp_pkg::wr_evt_t NO_EVT = '0;

    // Register indices
    localparam logic [2:0] R0 = 3'd0;
    localparam logic [2:0] R1 = 3'd1;
    localparam logic [2:0] R2 = 3'd2;
    localparam logic [2:0] R3 = 3'd3;
    localparam logic [2:0] RJ = 3'd4;
    localparam logic [2:0] RK = 3'd5;
    localparam logic [2:0] RB = 3'd6;
    localparam logic [2:0] RE = 3'd7;

    localparam logic [1:0] MOD_NONE = 2'd0;
    localparam logic [1:0] MOD_INC  = 2'd1;
    localparam logic [1:0] MOD_DEC  = 2'd2;
    localparam logic [1:0] MOD_J    = 2'd3;

    logic                 clk;
    logic                 rst;
    logic                 cen;
    dsp_pkg::instr_u      instr;
    logic [`DSP_PC_W-1:0] pc;
    dsp_pkg::wr_evt_t     wr_evt;

    logic                 row_cen   [MAX_ROWS];
    dsp_pkg::instr_u      row_instr [MAX_ROWS];
    logic [`DSP_PC_W-1:0] row_pc    [MAX_ROWS];
    dsp_pkg::wr_evt_t     row_wr    [MAX_ROWS];
    int                   nrows;

    logic [`DSP_PC_W-1:0] pc_model;      // Expected pc while rows are added
    logic                 jmp_pending;
    logic [`DSP_PC_W-1:0] jmp_dest;
    logic [31:0]          lfsr_state;
    int                   cycles = 0;
    int                   cycle_limit = 0;

    dsp_core UUT (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .instr  (instr),
        .pc     (pc),
        .wr_evt (wr_evt)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;   // Taps 32 22 2 1
        end
        return n;
    endfunction

    task automatic draw9(output logic [8:0] v);
        v = '0;
        for (int i = 0; i < 9; i++) begin
            v = {v[7:0], lfsr_state[0]};   // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic dsp_pkg::instr_u short_word(input logic [2:0] idx, input logic [8:0] imm);
        dsp_pkg::instr_u w;
        w.imm_fmt.pfx = 4'b0001;
        w.imm_fmt.rf  = idx ^ 3'b100;   // Code 1xx selects r0 to r3
        w.imm_fmt.imm = imm;
        return w;
    endfunction

    function automatic dsp_pkg::instr_u mem_word(input logic [4:0] t, input logic [2:0] rf,
                                                 input logic [1:0] ysel, input logic [1:0] md);
        dsp_pkg::instr_u w;
        w.mem_fmt.t     = t;
        w.mem_fmt.spare = 1'b0;
        w.mem_fmt.grp   = 3'd0;
        w.mem_fmt.rf    = rf;
        w.mem_fmt.ysel  = ysel;
        w.mem_fmt.mod   = md;
        return w;
    endfunction

    function automatic dsp_pkg::wr_evt_t write_of(input logic [7:0] a, input logic [15:0] d);
        dsp_pkg::wr_evt_t e;
        e.valid = 1'b1;
        e.addr  = a;
        e.data  = d;
        return e;
    endfunction

    task automatic add_row(input logic c, input dsp_pkg::instr_u w, input dsp_pkg::wr_evt_t e);
        if (c) begin
            if (jmp_pending) begin
                pc_model    = jmp_dest;
                jmp_pending = 1'b0;
            end else begin
                pc_model = pc_model + 12'd1;
            end
        end
        row_cen[nrows]   = c;
        row_instr[nrows] = w;
        row_pc[nrows]    = pc_model;
        row_wr[nrows]    = e;
        nrows++;
    endtask

    // Target lands at the next enabled edge
    task automatic add_goto(input logic [`DSP_PC_W-1:0] dest);
        dsp_pkg::instr_u w;
        w.jmp_fmt.t  = {4'b0000, dest[11]};
        w.jmp_fmt.ja = dest[10:0];
        add_row(1'b1, w, NO_EVT);
        jmp_pending = 1'b1;
        jmp_dest    = dest;
    endtask

    task automatic check_pc(input logic [`DSP_PC_W-1:0] exp);
        if (pc !== exp) begin
            $display("** Error at %0d ns: pc = %h, expected %h", $time, pc, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_wr(input dsp_pkg::wr_evt_t exp);
        logic bad;
        if (exp.valid) begin
            bad = (wr_evt !== exp);
        end else begin
            bad = (wr_evt.valid !== 1'b0);   // Payload is stale without valid
        end
        if (bad) begin
            $display("** Error at %0d ns: wr_evt = {%b, %h, %h}, expected {%b, %h, %h}",
                     $time, wr_evt.valid, wr_evt.addr, wr_evt.data,
                     exp.valid, exp.addr, exp.data);
            $display("SIMULATION FAILED");
            $fatal(1, "wr_evt mismatch");
        end
    endtask

    task automatic build_table();
        logic [8:0] v0;
        logic [8:0] v1;
        logic [8:0] v2;
        nrows       = 0;
        pc_model    = '0;
        jmp_pending = 1'b0;
        jmp_dest    = '0;
        draw9(v0);
        draw9(v1);
        draw9(v2);
        // pc counts only enabled edges
        add_row(1'b1, NOP_WORD, NO_EVT);
        add_row(1'b0, NOP_WORD, NO_EVT);
        add_row(1'b0, NOP_WORD, NO_EVT);
        add_row(1'b1, NOP_WORD, NO_EVT);
        // Short immediates, stored through r0
        add_row(1'b1, short_word(R0, v0), NO_EVT);
        add_row(1'b1, short_word(RB, v1), NO_EVT);
        add_row(1'b1, short_word(RE, v2), NO_EVT);
        add_row(1'b1, mem_word(`DSP_T_STORE, R0, 2'd0, MOD_NONE), NO_EVT);
        add_row(1'b1, mem_word(`DSP_T_STORE, RB, 2'd0, MOD_NONE), write_of(v0[7:0], {7'd0, v0}));
        add_row(1'b1, mem_word(`DSP_T_STORE, RE, 2'd0, MOD_NONE), write_of(v0[7:0], {7'd0, v1}));
        add_row(1'b1, NOP_WORD, write_of(v0[7:0], {7'd0, v2}));
        add_row(1'b1, NOP_WORD, NO_EVT);
        // Two-word load of k
        add_row(1'b1, mem_word(`DSP_T_LONG, RK, 2'd0, MOD_NONE), NO_EVT);
        add_row(1'b1, LONG_DATA, NO_EVT);
        add_row(1'b1, short_word(R1, 9'h042), NO_EVT);
        add_row(1'b1, mem_word(`DSP_T_STORE, RK, 2'd1, MOD_NONE), NO_EVT);
        add_row(1'b1, NOP_WORD, write_of(8'h42, LONG_DATA));
        // Post-modify of r2 with j = 3
        add_row(1'b1, short_word(RJ, 9'd3), NO_EVT);
        add_row(1'b1, short_word(R2, 9'h010), NO_EVT);
        add_row(1'b1, mem_word(`DSP_T_STORE, R0, 2'd2, MOD_INC), NO_EVT);
        add_row(1'b0, mem_word(`DSP_T_STORE, R0, 2'd2, MOD_INC), NO_EVT);   // Not sampled
        add_row(1'b1, mem_word(`DSP_T_STORE, R0, 2'd2, MOD_INC), write_of(8'h10, {7'd0, v0}));
        add_row(1'b1, mem_word(`DSP_T_STORE, R0, 2'd2, MOD_DEC), write_of(8'h11, {7'd0, v0}));
        add_row(1'b1, mem_word(`DSP_T_STORE, R0, 2'd2, MOD_J), write_of(8'h12, {7'd0, v0}));
        add_row(1'b1, mem_word(`DSP_T_STORE, R0, 2'd2, MOD_NONE), write_of(8'h11, {7'd0, v0}));
        add_row(1'b1, NOP_WORD, write_of(8'h14, {7'd0, v0}));
        add_row(1'b1, NOP_WORD, NO_EVT);
        // Store rb, load it back into r3, store r3 through r2
        add_row(1'b1, short_word(R1, 9'h080), NO_EVT);
        add_row(1'b1, mem_word(`DSP_T_STORE, RB, 2'd1, MOD_NONE), NO_EVT);
        add_row(1'b1, mem_word(`DSP_T_LOAD, R3, 2'd1, MOD_NONE), write_of(8'h80, {7'd0, v1}));
        add_row(1'b1, mem_word(`DSP_T_STORE, R3, 2'd2, MOD_NONE), NO_EVT);
        add_row(1'b1, NOP_WORD, write_of(8'h14, {7'd0, v1}));
        // Jump with a store in the slot
        add_goto(12'hb35);
        add_row(1'b0, NOP_WORD, NO_EVT);
        add_row(1'b1, mem_word(`DSP_T_STORE, R0, 2'd0, MOD_NONE), NO_EVT);
        add_row(1'b1, NOP_WORD, NO_EVT);
        add_row(1'b1, NOP_WORD, NO_EVT);
    endtask

    initial begin
        rst        = 1'b1;
        cen        = 1'b0;
        instr      = '0;
        lfsr_state = 32'hc721d6ab;
        build_table();
        cycle_limit = nrows + RST_CYCLES + 20;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_pc('0);
        check_wr(NO_EVT);
        for (int i = 0; i < nrows; i++) begin
            cen   = row_cen[i];
            instr = row_instr[i];
            @(negedge clk);
            check_pc(row_pc[i]);
            check_wr(row_wr[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
